// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= issue_read_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^Test OK$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/isa_pkg.sv
package isa_pkg;

    // architectural widths
    localparam int REG_IDX_W = 5;
    localparam int WORD_W = 32;
    localparam int UOP_W = 8;

    // r0 reads as zero, r1..r31 are writable
    localparam int NUM_ARCH_REGS = 32;

    // uop flag positions
    // memory access of any kind
    localparam int UOP_MEM_BIT = 7;
    // store when set, a load when clear on a memory uop
    localparam int UOP_STORE_BIT = 6;

    // register index into the 32 entry file
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // data word, also used for pc and immediate
    typedef logic [WORD_W-1:0] word_t;

    // micro-op code from decode
    // upper bits carry class flags, lower bits the operation
    typedef logic [UOP_W-1:0] uop_t;

endpackage

// File: design/issue_read_top.sv
`timescale 1ns/100ps

module issue_read_top (
    input  logic                 clk,
    input  logic                 aresetn,
    input  logic                 flush,
    input  pipe_pkg::id_bundle_t in_bundle,
    output logic                 in_allowin,
    input  pipe_pkg::wb_port_t   wb [pipe_pkg::NUM_WB_PORTS],
    input  pipe_pkg::fwd_t       fwd [pipe_pkg::NUM_OPERANDS],
    input  logic                 ex_allowin,
    output pipe_pkg::ex_bundle_t out_bundle
);

    isa_pkg::reg_idx_t raddr [pipe_pkg::NUM_OPERANDS];
    isa_pkg::word_t    rdata [pipe_pkg::NUM_OPERANDS];
    logic              stall;
    logic              out_fire;

    // read ports follow operand order
    assign raddr[pipe_pkg::OPND_RJ0] = in_bundle.slot0.rj;
    assign raddr[pipe_pkg::OPND_RK0] = in_bundle.slot0.rk;
    assign raddr[pipe_pkg::OPND_RJ1] = in_bundle.slot1.rj;
    assign raddr[pipe_pkg::OPND_RK1] = in_bundle.slot1.rk;

    regfile u_regfile (
        .clk     (clk),
        .aresetn (aresetn),
        .wb      (wb),
        .raddr   (raddr),
        .rdata   (rdata)
    );

    // watches the held pair against the incoming one
    load_use_hazard u_hazard (
        .clk        (clk),
        .aresetn    (aresetn),
        .in_bundle  (in_bundle),
        .out_bundle (out_bundle),
        .out_fire   (out_fire),
        .stall      (stall)
    );

    operand_read_stage u_stage (
        .clk        (clk),
        .aresetn    (aresetn),
        .flush      (flush),
        .in_bundle  (in_bundle),
        .rdata      (rdata),
        .stall      (stall),
        .fwd        (fwd),
        .ex_allowin (ex_allowin),
        .in_allowin (in_allowin),
        .out_fire   (out_fire),
        .out_bundle (out_bundle)
    );

endmodule

// File: design/load_use_hazard.sv
`timescale 1ns/100ps

module load_use_hazard (
    input  logic                 clk,
    input  logic                 aresetn,
    input  pipe_pkg::id_bundle_t in_bundle,
    input  pipe_pkg::ex_bundle_t out_bundle,
    input  logic                 out_fire,
    output logic                 stall
);

    // destinations of loads that already left, newest at index 0
    isa_pkg::reg_idx_t hist_q [pipe_pkg::LOAD_SHADOW];

    // rd of the load sitting in the output register, else r0
    isa_pkg::reg_idx_t held_load_rd;
    logic              held_is_load;

    // output slot left with no load in it
    logic              clean_fire;

    // incoming sources in operand order
    isa_pkg::reg_idx_t src [pipe_pkg::NUM_OPERANDS];
    logic              dep_hit;

    // only slot 0 can hold a load
    assign held_is_load = out_bundle.valid
                        && out_bundle.slot0.uop[isa_pkg::UOP_MEM_BIT]
                        && !out_bundle.slot0.uop[isa_pkg::UOP_STORE_BIT];
    assign held_load_rd = held_is_load ? out_bundle.slot0.rd : '0;

    assign clean_fire = out_fire && !held_is_load;

    assign src[pipe_pkg::OPND_RJ0] = in_bundle.slot0.rj;
    assign src[pipe_pkg::OPND_RK0] = in_bundle.slot0.rk;
    assign src[pipe_pkg::OPND_RJ1] = in_bundle.slot1.rj;
    assign src[pipe_pkg::OPND_RK1] = in_bundle.slot1.rk;

    // shifts once per output slot, bubbles push r0
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < pipe_pkg::LOAD_SHADOW; i++) begin
                hist_q[i] <= '0;
            end
        end else if (out_fire) begin
            hist_q[0] <= held_load_rd;
            for (int i = 1; i < pipe_pkg::LOAD_SHADOW; i++) begin
                hist_q[i] <= hist_q[i-1];
            end
        end
    end

    // r0 sources never depend on anything
    always_comb begin
        dep_hit = 1'b0;
        for (int s = 0; s < pipe_pkg::NUM_OPERANDS; s++) begin
            if (src[s] != '0) begin
                if (src[s] == held_load_rd) begin
                    dep_hit = 1'b1;
                end
                for (int h = 0; h < pipe_pkg::LOAD_SHADOW; h++) begin
                    if (src[s] == hist_q[h]) begin
                        dep_hit = 1'b1;
                    end
                end
            end
        end
    end

    assign stall = dep_hit && in_bundle.valid;

    // two clean transfers refill both history entries with r0
    // so only a held load could still stall
    a_shadow_expires: assert property (
        @(posedge clk) disable iff (!aresetn)
        $past(clean_fire, 1) && $past(clean_fire, 2) && !held_is_load |-> !stall
    );

endmodule

// File: design/operand_read_stage.sv
`timescale 1ns/100ps

module operand_read_stage (
    input  logic                 clk,
    input  logic                 aresetn,
    input  logic                 flush,
    input  pipe_pkg::id_bundle_t in_bundle,
    input  isa_pkg::word_t       rdata [pipe_pkg::NUM_OPERANDS],
    input  logic                 stall,
    input  pipe_pkg::fwd_t       fwd [pipe_pkg::NUM_OPERANDS],
    input  logic                 ex_allowin,
    output logic                 in_allowin,
    output logic                 out_fire,
    output pipe_pkg::ex_bundle_t out_bundle
);

    // control
    logic valid_q;
    logic advance;
    logic in_fire;

    // payload
    pipe_pkg::slot_t slot0_q;
    pipe_pkg::slot_t slot1_q;
    isa_pkg::word_t  opnd_q [pipe_pkg::NUM_OPERANDS];

    // valid pair held while execute refuses it
    logic held;

    // register may take new contents when empty or draining
    assign advance = ex_allowin || !valid_q;
    assign in_allowin = advance && !stall;
    assign in_fire = in_bundle.valid && in_allowin;

    // one execute slot passes per allowed cycle
    // bubbles count too, so the load history ages
    assign out_fire = ex_allowin;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            // flush beats a same-cycle accept
            valid_q <= 1'b0;
        end else if (advance) begin
            // bubble when nothing replaces the leaving pair
            valid_q <= in_fire;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            slot0_q <= in_bundle.slot0;
            slot1_q <= in_bundle.slot1;
            for (int i = 0; i < pipe_pkg::NUM_OPERANDS; i++) begin
                opnd_q[i] <= rdata[i];
            end
        end else begin
            // late results overwrite held operands
            for (int i = 0; i < pipe_pkg::NUM_OPERANDS; i++) begin
                if (fwd[i].valid) begin
                    opnd_q[i] <= fwd[i].data;
                end
            end
        end
    end

    always_comb begin
        out_bundle.slot0 = slot0_q;
        out_bundle.slot1 = slot1_q;
        out_bundle.rj0_data = opnd_q[pipe_pkg::OPND_RJ0];
        out_bundle.rk0_data = opnd_q[pipe_pkg::OPND_RK0];
        out_bundle.rj1_data = opnd_q[pipe_pkg::OPND_RJ1];
        out_bundle.rk1_data = opnd_q[pipe_pkg::OPND_RK1];
        out_bundle.valid = valid_q;
    end

    assign held = valid_q && !ex_allowin && !flush;

    // instructions of a stalled pair stay put
    a_hold_slots: assert property (
        @(posedge clk) disable iff (!aresetn)
        held |=> valid_q && $stable(slot0_q) && $stable(slot1_q)
    );

    // held operands change only through forwarding
    for (genvar g = 0; g < pipe_pkg::NUM_OPERANDS; g++) begin : g_hold_opnd
        a_hold_opnd: assert property (
            @(posedge clk) disable iff (!aresetn)
            held |=> opnd_q[g] == ($past(fwd[g].valid) ? $past(fwd[g].data)
                                                       : $past(opnd_q[g]))
        );
    end

endmodule

// File: design/pipe_pkg.sv
package pipe_pkg;

    // load result unavailable for this many slots after it leaves
    localparam int LOAD_SHADOW = 2;

    // two write-back ports, port 1 is the younger one
    localparam int NUM_WB_PORTS = 2;

    // source operands per pair, also the read port count
    localparam int NUM_OPERANDS = 4;

    // operand order shared by read ports, forwarding and capture
    localparam int OPND_RJ0 = 0;
    localparam int OPND_RK0 = 1;
    localparam int OPND_RJ1 = 2;
    localparam int OPND_RK1 = 3;

    // one decoded instruction
    typedef struct packed {
        isa_pkg::uop_t     uop;
        isa_pkg::reg_idx_t rj;
        isa_pkg::reg_idx_t rk;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    imm;
        isa_pkg::word_t    pc;
    } slot_t;

    // pair from decode, valid doubles as readygo
    typedef struct packed {
        slot_t slot0;
        slot_t slot1;
        logic  valid;
    } id_bundle_t;

    // register write from write-back
    typedef struct packed {
        logic              we;
        isa_pkg::reg_idx_t addr;
        isa_pkg::word_t    data;
    } wb_port_t;

    // late result for one held operand
    typedef struct packed {
        logic           valid;
        isa_pkg::word_t data;
    } fwd_t;

    // pair toward execute with its operands
    typedef struct packed {
        slot_t          slot0;
        slot_t          slot1;
        isa_pkg::word_t rj0_data;
        isa_pkg::word_t rk0_data;
        isa_pkg::word_t rj1_data;
        isa_pkg::word_t rk1_data;
        logic           valid;
    } ex_bundle_t;

endpackage

// File: design/regfile.sv
`timescale 1ns/100ps

module regfile (
    input  logic               clk,
    input  logic               aresetn,
    input  pipe_pkg::wb_port_t wb [pipe_pkg::NUM_WB_PORTS],
    input  isa_pkg::reg_idx_t  raddr [pipe_pkg::NUM_OPERANDS],
    output isa_pkg::word_t     rdata [pipe_pkg::NUM_OPERANDS]
);

    // entry 0 is kept but never written
    isa_pkg::word_t [isa_pkg::NUM_ARCH_REGS-1:0] regs;

    // every active write port targets r0
    logic zero_only_write;

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            regs <= '0;
        end else begin
            // later iteration wins so port 1 has priority
            for (int p = 0; p < pipe_pkg::NUM_WB_PORTS; p++) begin
                if (wb[p].we && (wb[p].addr != '0)) begin
                    regs[wb[p].addr] <= wb[p].data;
                end
            end
        end
    end

    // combinational read with write-through
    always_comb begin
        for (int r = 0; r < pipe_pkg::NUM_OPERANDS; r++) begin
            rdata[r] = regs[raddr[r]];
            // bypass same-cycle write, port 1 checked last
            for (int p = 0; p < pipe_pkg::NUM_WB_PORTS; p++) begin
                if (wb[p].we && (wb[p].addr == raddr[r])) begin
                    rdata[r] = wb[p].data;
                end
            end
            // r0 stays zero even on a bypassed write
            if (raddr[r] == '0) begin
                rdata[r] = '0;
            end
        end
    end

    assign zero_only_write = (wb[0].we || wb[1].we)
                           && (!wb[0].we || (wb[0].addr == '0))
                           && (!wb[1].we || (wb[1].addr == '0));

    // writes aimed at r0 leave the whole file untouched
    a_zero_write_inert: assert property (
        @(posedge clk) disable iff (!aresetn)
        zero_only_write |=> $stable(regs)
    );

endmodule

// File: include/issue_read_tests.svh
`ifndef ISSUE_READ_TESTS_SVH
`define ISSUE_READ_TESTS_SVH

// zero register and reset state
task automatic test_reset_zero();
    pipe_pkg::slot_t s0;
    pipe_pkg::slot_t s1;
    cur_test = "reset_zero";
    #1;
    check_bit("in_allowin after reset", 1'b1, in_allowin);
    check_bit("out valid after reset", 1'b0, out_bundle.valid);
    // both ports aim at r0
    write_regs(5'd0, $random(seed), 5'd0, $random(seed));
    s0 = make_slot(ALU_UOP, 5'd0, 5'd3, 5'd4);
    s1 = make_slot(ALU_UOP, 5'd17, 5'd0, 5'd9);
    accept_pair(s0, s1);
    check_out("zero pair", s0, s1, '0, '0, '0, '0);
    // a same-cycle r0 write must not bypass into the read
    set_wb(1'b1, 5'd0, $random(seed), 1'b0, 5'd0, '0);
    accept_pair(s1, s0);
    check_out("r0 bypass", s1, s0, '0, '0, '0, '0);
endtask

// readback, write-through and port priority
task automatic test_readback();
    pipe_pkg::slot_t s0;
    pipe_pkg::slot_t s1;
    isa_pkg::word_t  late;
    cur_test = "readback";
    write_regs(5'd5, $random(seed), 5'd6, $random(seed));
    write_regs(5'd7, $random(seed), 5'd8, $random(seed));
    write_regs(5'd11, $random(seed), 5'd12, $random(seed));
    s0 = make_slot(ALU_UOP, 5'd5, 5'd6, 5'd1);
    s1 = make_slot(ALU_UOP, 5'd11, 5'd12, 5'd2);
    accept_pair(s0, s1);
    check_pair_out("four operands", s0, s1);
    // r20 written in the same cycle it is read
    set_wb(1'b1, 5'd20, $random(seed), 1'b0, 5'd0, '0);
    s0 = make_slot(ALU_UOP, 5'd20, 5'd7, 5'd3);
    s1 = make_slot(ALU_UOP, 5'd8, 5'd20, 5'd3);
    accept_pair(s0, s1);
    check_pair_out("write-through", s0, s1);
    // both ports hit r21, younger port wins
    late = $random(seed);
    set_wb(1'b1, 5'd21, $random(seed), 1'b1, 5'd21, late);
    s0 = make_slot(ALU_UOP, 5'd21, 5'd5, 5'd4);
    s1 = make_slot(ALU_UOP, 5'd6, 5'd21, 5'd4);
    accept_pair(s0, s1);
    check_word("port 1 bypass", late, out_bundle.rj0_data);
    check_pair_out("double write bypass", s0, s1);
    // stored copy after the double write
    s0 = make_slot(ALU_UOP, 5'd21, 5'd20, 5'd5);
    accept_pair(s0, s1);
    check_word("port 1 stored", late, out_bundle.rj0_data);
    check_pair_out("double write stored", s0, s1);
endtask

// load in slot 0 blocks its consumers
task automatic test_load_use();
    pipe_pkg::slot_t ld;
    pipe_pkg::slot_t s1;
    pipe_pkg::slot_t d0;
    pipe_pkg::slot_t d1;
    int              waited;
    cur_test = "load_use";
    ld = make_slot(LOAD_UOP, 5'd5, 5'd6, 5'd9);
    s1 = make_slot(ALU_UOP, 5'd7, 5'd8, 5'd10);
    accept_pair(ld, s1);
    check_pair_out("load pair", ld, s1);
    // slot 1 rk sources the load destination
    d0 = make_slot(ALU_UOP, 5'd11, 5'd12, 5'd13);
    d1 = make_slot(ALU_UOP, 5'd5, 5'd9, 5'd14);
    offer_until_accepted(d0, d1, waited);
    // one cycle held plus the shadow
    check_word("stall cycles", pipe_pkg::LOAD_SHADOW + 1, waited);
    check_pair_out("dependent pair", d0, d1);
    // unrelated pair behind a fresh load
    ld = make_slot(LOAD_UOP, 5'd7, 5'd8, 5'd15);
    accept_pair(ld, s1);
    d0 = make_slot(ALU_UOP, 5'd16, 5'd17, 5'd18);
    d1 = make_slot(ALU_UOP, 5'd19, 5'd0, 5'd15);
    accept_pair(d0, d1);
    check_pair_out("independent pair", d0, d1);
endtask

// execute refuses the pair for a while
task automatic test_back_pressure();
    pipe_pkg::slot_t s0;
    pipe_pkg::slot_t s1;
    pipe_pkg::slot_t n0;
    pipe_pkg::slot_t n1;
    isa_pkg::word_t  f1;
    isa_pkg::word_t  f2;
    cur_test = "back_pressure";
    // last pair of the previous test leaves, a bubble follows
    step();
    check_bit("bubble after drain", 1'b0, out_bundle.valid);
    ex_allowin = 1'b0;
    s0 = make_slot(ALU_UOP, 5'd5, 5'd6, 5'd1);
    s1 = make_slot(ALU_UOP, 5'd7, 5'd8, 5'd2);
    // empty register still takes a pair
    accept_pair(s0, s1);
    check_pair_out("held pair", s0, s1);
    n0 = make_slot(ALU_UOP, 5'd11, 5'd12, 5'd3);
    n1 = make_slot(ALU_UOP, 5'd20, 5'd21, 5'd4);
    present_pair(n0, n1);
    #1;
    check_bit("in_allowin while full", 1'b0, in_allowin);
    // late results for rk0 and rj1 only
    f1 = $random(seed);
    f2 = $random(seed);
    fwd[pipe_pkg::OPND_RK0].valid = 1'b1;
    fwd[pipe_pkg::OPND_RK0].data = f1;
    fwd[pipe_pkg::OPND_RJ1].valid = 1'b1;
    fwd[pipe_pkg::OPND_RJ1].data = f2;
    step();
    clear_fwd();
    check_out("forwarded", s0, s1, model_read(5'd5), f1, f2, model_read(5'd8));
    step();
    check_out("still held", s0, s1, model_read(5'd5), f1, f2, model_read(5'd8));
    // release: updated pair leaves, next one enters
    ex_allowin = 1'b1;
    #1;
    check_bit("in_allowin on release", 1'b1, in_allowin);
    check_out("released", s0, s1, model_read(5'd5), f1, f2, model_read(5'd8));
    step();
    in_bundle.valid = 1'b0;
    check_pair_out("after release", n0, n1);
endtask

// flush alone and flush racing an accept
task automatic test_flush();
    pipe_pkg::slot_t s0;
    pipe_pkg::slot_t s1;
    cur_test = "flush";
    s0 = make_slot(ALU_UOP, 5'd5, 5'd6, 5'd1);
    s1 = make_slot(ALU_UOP, 5'd7, 5'd8, 5'd2);
    accept_pair(s0, s1);
    check_bit("valid before flush", 1'b1, out_bundle.valid);
    flush = 1'b1;
    step();
    flush = 1'b0;
    check_bit("valid after flush", 1'b0, out_bundle.valid);
    flush = 1'b1;
    present_pair(s1, s0);
    #1;
    check_bit("in_allowin empty", 1'b1, in_allowin);
    step();
    flush = 1'b0;
    in_bundle.valid = 1'b0;
    check_bit("dropped on flush", 1'b0, out_bundle.valid);
    accept_pair(s1, s0);
    check_pair_out("after flush", s1, s0);
endtask

// one pair per cycle, in order
task automatic test_throughput();
    pipe_pkg::slot_t p0 [NUM_PAIRS];
    pipe_pkg::slot_t p1 [NUM_PAIRS];
    cur_test = "throughput";
    for (int i = 0; i < NUM_PAIRS; i++) begin
        p0[i] = make_slot(ALU_UOP, rand_reg(), rand_reg(), rand_reg());
        p1[i] = make_slot(ALU_UOP, rand_reg(), rand_reg(), rand_reg());
    end
    for (int i = 0; i <= NUM_PAIRS; i++) begin
        if (i > 0) begin
            check_pair_out("stream", p0[i-1], p1[i-1]);
        end
        if (i < NUM_PAIRS) begin
            present_pair(p0[i], p1[i]);
            #1;
            check_bit("in_allowin stream", 1'b1, in_allowin);
        end else begin
            in_bundle.valid = 1'b0;
        end
        step();
    end
    check_bit("drained", 1'b0, out_bundle.valid);
endtask

`endif

// File: dv/issue_read_tb.sv
`timescale 1ns/100ps

module issue_read_tb;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_PAIRS = 6;
    // upper bound for one stalled offer
    localparam int STALL_LIMIT = 20;
    // rough cycle budget per test, reset first
    localparam int RUN_CYCLES = 3 + 8 + 20 + 16 + 12 + 10 + NUM_PAIRS + 4;
    localparam int WATCHDOG_NS = RUN_CYCLES * CLK_PERIOD + 500;

    // memory access with store bit clear
    localparam isa_pkg::uop_t LOAD_UOP = isa_pkg::uop_t'(1 << isa_pkg::UOP_MEM_BIT) | 8'h03;
    localparam isa_pkg::uop_t ALU_UOP = 8'h01;

    logic                 clk;
    logic                 aresetn;
    logic                 flush;
    pipe_pkg::id_bundle_t in_bundle;
    logic                 in_allowin;
    pipe_pkg::wb_port_t   wb [pipe_pkg::NUM_WB_PORTS];
    pipe_pkg::fwd_t       fwd [pipe_pkg::NUM_OPERANDS];
    logic                 ex_allowin;
    pipe_pkg::ex_bundle_t out_bundle;

    // architectural state as the testbench expects it
    isa_pkg::word_t ref_regs [isa_pkg::NUM_ARCH_REGS];

    int    seed = 32'h5b57a087;
    int    checks = 0;
    int    errors = 0;
    string cur_test = "none";

    issue_read_top uut (
        .clk        (clk),
        .aresetn    (aresetn),
        .flush      (flush),
        .in_bundle  (in_bundle),
        .in_allowin (in_allowin),
        .wb         (wb),
        .fwd        (fwd),
        .ex_allowin (ex_allowin),
        .out_bundle (out_bundle)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAILED %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_word(input string what, input isa_pkg::word_t exp,
                              input isa_pkg::word_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_slot(input string what, input pipe_pkg::slot_t exp,
                              input pipe_pkg::slot_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    // r0 reads zero whatever was written
    function automatic isa_pkg::word_t model_read(input isa_pkg::reg_idx_t a);
        return (a == '0) ? '0 : ref_regs[a];
    endfunction

    function automatic isa_pkg::reg_idx_t rand_reg();
        return isa_pkg::reg_idx_t'($random(seed));
    endfunction

    // imm and pc are random filler
    function automatic pipe_pkg::slot_t make_slot(input isa_pkg::uop_t uop,
                                                  input isa_pkg::reg_idx_t rj,
                                                  input isa_pkg::reg_idx_t rk,
                                                  input isa_pkg::reg_idx_t rd);
        pipe_pkg::slot_t s;
        s.uop = uop;
        s.rj = rj;
        s.rk = rk;
        s.rd = rd;
        s.imm = $random(seed);
        s.pc = $random(seed);
        return s;
    endfunction

    task automatic step();
        @(posedge clk);
        @(negedge clk);
    endtask

    task automatic present_pair(input pipe_pkg::slot_t s0, input pipe_pkg::slot_t s1);
        in_bundle.slot0 = s0;
        in_bundle.slot1 = s1;
        in_bundle.valid = 1'b1;
    endtask

    task automatic set_wb(input logic we0, input isa_pkg::reg_idx_t a0,
                          input isa_pkg::word_t d0, input logic we1,
                          input isa_pkg::reg_idx_t a1, input isa_pkg::word_t d1);
        wb[0].we = we0;
        wb[0].addr = a0;
        wb[0].data = d0;
        wb[1].we = we1;
        wb[1].addr = a1;
        wb[1].data = d1;
    endtask

    task automatic clear_fwd();
        for (int i = 0; i < pipe_pkg::NUM_OPERANDS; i++) begin
            fwd[i] = '0;
        end
    endtask

    // port 0 first so port 1 lands last
    task automatic commit_wb_model();
        for (int p = 0; p < pipe_pkg::NUM_WB_PORTS; p++) begin
            if (wb[p].we && (wb[p].addr != '0)) begin
                ref_regs[wb[p].addr] = wb[p].data;
            end
        end
    endtask

    task automatic write_regs(input isa_pkg::reg_idx_t a0, input isa_pkg::word_t d0,
                              input isa_pkg::reg_idx_t a1, input isa_pkg::word_t d1);
        set_wb(1'b1, a0, d0, 1'b1, a1, d1);
        commit_wb_model();
        step();
        set_wb(1'b0, '0, '0, 1'b0, '0, '0);
    endtask

    // holds the pair on the bus until in_allowin, counting blocked cycles
    task automatic offer_until_accepted(input pipe_pkg::slot_t s0,
                                        input pipe_pkg::slot_t s1, output int waited);
        waited = 0;
        present_pair(s0, s1);
        #1;
        while (!in_allowin && (waited < STALL_LIMIT)) begin
            @(negedge clk);
            #1;
            waited++;
        end
        checks++;
        assert (in_allowin) else begin
            errors++;
            $display("%s: pair never accepted, in_allowin stayed low", cur_test);
        end
        commit_wb_model();
        step();
        in_bundle.valid = 1'b0;
        set_wb(1'b0, '0, '0, 1'b0, '0, '0);
    endtask

    task automatic accept_pair(input pipe_pkg::slot_t s0, input pipe_pkg::slot_t s1);
        int waited;
        offer_until_accepted(s0, s1, waited);
        check_word("accept without stall", '0, waited);
    endtask

    task automatic check_out(input string what, input pipe_pkg::slot_t s0,
                             input pipe_pkg::slot_t s1, input isa_pkg::word_t d0,
                             input isa_pkg::word_t d1, input isa_pkg::word_t d2,
                             input isa_pkg::word_t d3);
        check_bit({what, " valid"}, 1'b1, out_bundle.valid);
        check_slot({what, " slot0"}, s0, out_bundle.slot0);
        check_slot({what, " slot1"}, s1, out_bundle.slot1);
        check_word({what, " rj0"}, d0, out_bundle.rj0_data);
        check_word({what, " rk0"}, d1, out_bundle.rk0_data);
        check_word({what, " rj1"}, d2, out_bundle.rj1_data);
        check_word({what, " rk1"}, d3, out_bundle.rk1_data);
    endtask

    // operands expected straight from the register model
    task automatic check_pair_out(input string what, input pipe_pkg::slot_t s0,
                                  input pipe_pkg::slot_t s1);
        check_out(what, s0, s1, model_read(s0.rj), model_read(s0.rk),
                  model_read(s1.rj), model_read(s1.rk));
    endtask

    `include "issue_read_tests.svh"

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        aresetn = 1'b0;
        flush = 1'b0;
        ex_allowin = 1'b1;
        in_bundle = '0;
        set_wb(1'b0, '0, '0, 1'b0, '0, '0);
        clear_fwd();
        for (int r = 0; r < isa_pkg::NUM_ARCH_REGS; r++) begin
            ref_regs[r] = '0;
        end
        // two full cycles in reset, released on a falling edge
        repeat (2) @(negedge clk);
        aresetn = 1'b1;
        test_reset_zero();
        test_readback();
        test_load_use();
        test_back_pressure();
        test_flush();
        test_throughput();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
design/isa_pkg.sv
design/pipe_pkg.sv
design/regfile.sv
design/load_use_hazard.sv
design/operand_read_stage.sv
design/issue_read_top.sv
dv/issue_read_tb.sv
